// File: Makefile
SIM := obj_dir/sim_rx_scheduler

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f rx_scheduler.f \
	  --top-module tb_rx_scheduler -o sim_rx_scheduler
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

// File: include/rx_scheduler_settings.svh
`ifndef RX_SCHEDULER_SETTINGS_SVH
`define RX_SCHEDULER_SETTINGS_SVH

// Sizes
`define SCHED_IF_COUNT          3
`define SCHED_CORE_COUNT        8
`define SCHED_SLOT_COUNT        16
`define SCHED_CORE_W            3
`define SCHED_IF_W              2
`define SCHED_SLOT_W            5
`define SCHED_LINE_W            13

// Core select field inside the flow hash
`define SCHED_HASH_SEL_OFFSET   14

// Top four bits of the line count set to 7
`define SCHED_DROP_LIMIT_RST    13'd3584

`define SCHED_HASH_FIFO_DEPTH   8
`define SCHED_DESC_FIFO_DEPTH   4

`define SCHED_RD_DEFAULT        32'hFEFE_FEFE

// Host register codes, core side
`define SCHED_REG_ENABLE        4'd0
`define SCHED_REG_INCOME        4'd1
`define SCHED_REG_FLUSH         4'd2
`define SCHED_REG_SLOT_COUNT    4'd3

// Host register codes, interface side
`define SCHED_REG_DROP_COUNT    4'd2
`define SCHED_REG_DROP_LIMIT    4'd3

// Control message types
`define SCHED_MSG_RELEASE       4'd0
`define SCHED_MSG_INIT          4'd3

`endif

// File: rx_scheduler.f
+incdir+include
source/rx_scheduler_pkg.sv
source/sched_fifo.sv
source/slot_keeper.sv
source/host_cmd_regs.sv
source/desc_allocator.sv
source/rx_scheduler.sv
tb/sched_checker.sv
tb/tb_rx_scheduler.sv

// File: source/desc_allocator.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_scheduler_settings.svh"

module desc_allocator
  import rx_scheduler_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_r,
  input  logic [31:0]                   hash [`SCHED_IF_COUNT],
  input  logic [`SCHED_IF_COUNT-1:0]    hash_valid,
  input  logic [`SCHED_IF_COUNT-1:0]    desc_room,
  input  logic [`SCHED_SLOT_W-1:0]      slot_head [`SCHED_CORE_COUNT],
  input  logic [`SCHED_CORE_COUNT-1:0]  slot_valid,
  input  core_mask_t                    income_cores,
  input  logic [`SCHED_IF_COUNT-1:0]    almost_full,
  output logic [`SCHED_IF_COUNT-1:0]    hash_pop,
  output rx_desc_t                      desc [`SCHED_IF_COUNT],
  output logic [`SCHED_IF_COUNT-1:0]    desc_push,
  output logic [`SCHED_CORE_COUNT-1:0]  slot_take,
  output logic [31:0]                   drop_count [`SCHED_IF_COUNT]
);

  logic [`SCHED_IF_COUNT-1:0] req;
  logic [`SCHED_IF_W-1:0]     last_idx;
  logic [`SCHED_IF_W-1:0]     grant_idx;
  logic                       grant_v;
  logic [`SCHED_IF_COUNT-1:0] grant_r;
  logic [`SCHED_IF_W-1:0]     grant_idx_r;
  logic [`SCHED_CORE_W-1:0]   core_r;
  logic                       slot_ok;
  logic                       take_slot;
  logic                       drop_pkt;
  rx_desc_t                   desc_n;

  // Last cycle's winner sits out, its decision is still pending
  assign req = hash_valid & desc_room & ~grant_r;

  // Round robin, search starts right after the previous winner
  always_comb begin
    int cand;
    grant_v   = 1'b0;
    grant_idx = last_idx;
    for (int k = 1; k <= `SCHED_IF_COUNT; k++) begin
      cand = (int'(last_idx) + k) % `SCHED_IF_COUNT;
      if (!grant_v && req[cand]) begin
        grant_v   = 1'b1;
        grant_idx = `SCHED_IF_W'(cand);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      last_idx    <= `SCHED_IF_W'(`SCHED_IF_COUNT - 1);
      grant_r     <= '0;
      grant_idx_r <= '0;
    end else begin
      grant_r <= '0;
      if (grant_v) begin
        last_idx             <= grant_idx;
        grant_r[grant_idx]   <= 1'b1;
        grant_idx_r          <= grant_idx;
      end
    end
  end

  // Destination core picked from the hash at grant time
  always_ff @(posedge clk) begin
    core_r <= hash[grant_idx][`SCHED_HASH_SEL_OFFSET +: `SCHED_CORE_W];
  end

  // Decision cycle: take a slot, drop, or leave the hash for a retry
  assign slot_ok   = slot_valid[core_r] && income_cores[core_r];
  assign take_slot = (|grant_r) && slot_ok;
  assign drop_pkt  = (|grant_r) && !slot_ok && almost_full[grant_idx_r];
  assign hash_pop  = (take_slot || drop_pkt) ? grant_r : '0;
  assign desc_push = hash_pop;

  always_comb begin
    slot_take         = '0;
    slot_take[core_r] = take_slot;
  end

  always_comb begin
    desc_n.drop = drop_pkt;
    desc_n.hash = hash[grant_idx_r];
    desc_n.core = core_r;
    desc_n.slot = take_slot ? slot_head[core_r] : '0;
    for (int i = 0; i < `SCHED_IF_COUNT; i++)
      desc[i] = desc_n;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      for (int i = 0; i < `SCHED_IF_COUNT; i++)
        drop_count[i] <= '0;
    end else if (drop_pkt) begin
      drop_count[grant_idx_r] <= drop_count[grant_idx_r] + 1'b1;
    end
  end

  a_one_take: assert property (@(posedge clk) disable iff (rst_r)
    $onehot0(slot_take));

  // Room was checked at grant, a cycle before the push
  a_push_has_room: assert property (@(posedge clk) disable iff (rst_r)
    (desc_push & ~desc_room) == '0);

endmodule

`default_nettype wire

// File: source/host_cmd_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_scheduler_settings.svh"

module host_cmd_regs
  import rx_scheduler_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_r,
  input  host_cmd_t                   host_cmd,
  input  logic [31:0]                 host_wr_data,
  input  logic                        host_cmd_valid,
  input  logic [`SCHED_LINE_W-1:0]    line_count [`SCHED_IF_COUNT],
  input  logic [`SCHED_SLOT_W-1:0]    slot_count [`SCHED_CORE_COUNT],
  input  logic [31:0]                 drop_count [`SCHED_IF_COUNT],
  output logic [31:0]                 host_rd_data,
  output core_mask_t                  enabled_cores,
  output core_mask_t                  income_cores,
  output core_mask_t                  slots_flush,
  output logic [`SCHED_IF_COUNT-1:0]  almost_full
);

  host_cmd_t                cmd_r;
  logic [31:0]              wr_data_r;
  logic                     wr_r;
  logic [31:0]              rd_data_n;
  logic [`SCHED_LINE_W-1:0] line_count_r [`SCHED_IF_COUNT];
  logic [`SCHED_LINE_W-1:0] drop_limit;
  core_mask_t               wr_mask;

  assign wr_mask = wr_data_r[`SCHED_CORE_COUNT-1:0];

  always_ff @(posedge clk) begin
    cmd_r        <= host_cmd;
    wr_data_r    <= host_wr_data;
    line_count_r <= line_count;
    host_rd_data <= rd_data_n;
  end

  // Only writes aimed at the scheduler count
  always_ff @(posedge clk) begin
    if (rst_r)
      wr_r <= 1'b0;
    else
      wr_r <= host_cmd_valid && host_cmd.write && host_cmd.sched;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      enabled_cores <= '0;
      income_cores  <= '0;
      slots_flush   <= '0;
      drop_limit    <= `SCHED_DROP_LIMIT_RST;
    end else begin
      slots_flush <= '0;
      if (wr_r) begin
        case ({cmd_r.to_interface, cmd_r.reg_code})
          {1'b0, `SCHED_REG_ENABLE}: begin
            // A core leaving the enabled set stops taking interface traffic
            enabled_cores <= wr_mask;
            income_cores  <= income_cores & wr_mask;
          end
          {1'b0, `SCHED_REG_INCOME}:
            income_cores <= wr_mask & enabled_cores;
          {1'b0, `SCHED_REG_FLUSH}:
            slots_flush <= wr_mask;
          {1'b1, `SCHED_REG_DROP_LIMIT}:
            drop_limit <= wr_data_r[`SCHED_LINE_W-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      almost_full <= '0;
    end else begin
      for (int i = 0; i < `SCHED_IF_COUNT; i++)
        almost_full[i] <= (line_count_r[i] >= drop_limit);
    end
  end

  // Readback mux, one more register stage follows
  always_ff @(posedge clk) begin
    rd_data_n <= `SCHED_RD_DEFAULT;
    case ({cmd_r.to_interface, cmd_r.reg_code})
      {1'b0, `SCHED_REG_ENABLE}:
        rd_data_n <= 32'(enabled_cores);
      {1'b0, `SCHED_REG_INCOME}:
        rd_data_n <= 32'(income_cores);
      {1'b0, `SCHED_REG_SLOT_COUNT}:
        if (cmd_r.index < 4'(`SCHED_CORE_COUNT))
          rd_data_n <= 32'(slot_count[cmd_r.index[`SCHED_CORE_W-1:0]]);
      {1'b1, `SCHED_REG_DROP_COUNT}:
        if (cmd_r.index < 4'(`SCHED_IF_COUNT))
          rd_data_n <= drop_count[cmd_r.index[`SCHED_IF_W-1:0]];
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: source/rx_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_scheduler_settings.svh"

module rx_scheduler
  import rx_scheduler_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_r,
  input  logic [31:0]                  hash [`SCHED_IF_COUNT],
  input  logic [`SCHED_IF_COUNT-1:0]   hash_valid,
  output logic [`SCHED_IF_COUNT-1:0]   hash_ready,
  input  logic [`SCHED_LINE_W-1:0]     line_count [`SCHED_IF_COUNT],
  input  ctrl_msg_t                    ctrl_msg,
  input  logic [`SCHED_CORE_W-1:0]     ctrl_src,
  input  logic                         ctrl_valid,
  input  host_cmd_t                    host_cmd,
  input  logic [31:0]                  host_wr_data,
  input  logic                         host_cmd_valid,
  output logic [31:0]                  host_rd_data,
  output rx_desc_t                     desc [`SCHED_IF_COUNT],
  output logic [`SCHED_IF_COUNT-1:0]   desc_valid,
  input  logic [`SCHED_IF_COUNT-1:0]   desc_ready
);

  logic [31:0]                  hash_q [`SCHED_IF_COUNT];
  logic [`SCHED_IF_COUNT-1:0]   hash_q_valid;
  logic [`SCHED_IF_COUNT-1:0]   hash_pop;
  rx_desc_t                     desc_in [`SCHED_IF_COUNT];
  logic [`SCHED_IF_COUNT-1:0]   desc_push;
  logic [`SCHED_IF_COUNT-1:0]   desc_room;
  logic [`SCHED_SLOT_W-1:0]     slot_head [`SCHED_CORE_COUNT];
  logic [`SCHED_CORE_COUNT-1:0] slot_valid;
  logic [`SCHED_CORE_COUNT-1:0] slot_take;
  logic [`SCHED_SLOT_W-1:0]     slot_count [`SCHED_CORE_COUNT];
  logic [31:0]                  drop_count [`SCHED_IF_COUNT];
  core_mask_t                   enabled_cores;
  core_mask_t                   income_cores;
  core_mask_t                   slots_flush;
  logic [`SCHED_IF_COUNT-1:0]   almost_full;
  logic [`SCHED_CORE_COUNT-1:0] init_v;
  logic [`SCHED_CORE_COUNT-1:0] release_v;
  logic [`SCHED_SLOT_W-1:0]     msg_slot_r;

  for (genvar i = 0; i < `SCHED_IF_COUNT; i++) begin : g_if
    sched_fifo #(.DEPTH(`SCHED_HASH_FIFO_DEPTH), .WIDTH(32)) i_hash_q (
      .clk       (clk),
      .rst_r     (rst_r),
      .in_data   (hash[i]),
      .in_valid  (hash_valid[i]),
      .in_ready  (hash_ready[i]),
      .out_data  (hash_q[i]),
      .out_valid (hash_q_valid[i]),
      .out_ready (hash_pop[i])
    );

    sched_fifo #(.DEPTH(`SCHED_DESC_FIFO_DEPTH), .WIDTH($bits(rx_desc_t))) i_desc_q (
      .clk       (clk),
      .rst_r     (rst_r),
      .in_data   (desc_in[i]),
      .in_valid  (desc_push[i]),
      .in_ready  (desc_room[i]),
      .out_data  (desc[i]),
      .out_valid (desc_valid[i]),
      .out_ready (desc_ready[i])
    );
  end

  // Slot messages split into per-core strobes, other types ignored
  always_ff @(posedge clk) begin
    if (rst_r) begin
      init_v    <= '0;
      release_v <= '0;
    end else begin
      for (int c = 0; c < `SCHED_CORE_COUNT; c++) begin
        init_v[c]    <= ctrl_valid && (ctrl_msg.msg_type == `SCHED_MSG_INIT) &&
                        (ctrl_src == `SCHED_CORE_W'(c));
        release_v[c] <= ctrl_valid && (ctrl_msg.msg_type == `SCHED_MSG_RELEASE) &&
                        (ctrl_src == `SCHED_CORE_W'(c));
      end
    end
  end

  always_ff @(posedge clk) begin
    msg_slot_r <= ctrl_msg.slot;
  end

  for (genvar c = 0; c < `SCHED_CORE_COUNT; c++) begin : g_core
    slot_keeper i_slot_keeper (
      .clk           (clk),
      .rst_r         (rst_r),
      .flush         (slots_flush[c]),
      .init_valid    (init_v[c]),
      .release_valid (release_v[c]),
      .slot_in       (msg_slot_r),
      .take          (slot_take[c]),
      .slot_out      (slot_head[c]),
      .slot_valid    (slot_valid[c]),
      .slot_count    (slot_count[c]),
      .enq_err       ()
    );
  end

  host_cmd_regs i_host_cmd_regs (
    .clk            (clk),
    .rst_r          (rst_r),
    .host_cmd       (host_cmd),
    .host_wr_data   (host_wr_data),
    .host_cmd_valid (host_cmd_valid),
    .line_count     (line_count),
    .slot_count     (slot_count),
    .drop_count     (drop_count),
    .host_rd_data   (host_rd_data),
    .enabled_cores  (enabled_cores),
    .income_cores   (income_cores),
    .slots_flush    (slots_flush),
    .almost_full    (almost_full)
  );

  desc_allocator i_desc_allocator (
    .clk          (clk),
    .rst_r        (rst_r),
    .hash         (hash_q),
    .hash_valid   (hash_q_valid),
    .desc_room    (desc_room),
    .slot_head    (slot_head),
    .slot_valid   (slot_valid),
    .income_cores (income_cores),
    .almost_full  (almost_full),
    .hash_pop     (hash_pop),
    .desc         (desc_in),
    .desc_push    (desc_push),
    .slot_take    (slot_take),
    .drop_count   (drop_count)
  );

  // Interface traffic only lands on cores the host has enabled
  a_take_enabled: assert property (@(posedge clk) disable iff (rst_r)
    (slot_take & ~enabled_cores) == '0);

endmodule

`default_nettype wire

// File: source/rx_scheduler_pkg.sv
`default_nettype none

package rx_scheduler_pkg;

  `include "rx_scheduler_settings.svh"

  // 36-bit control message from a core
  typedef struct packed {
    logic [3:0]                  msg_type;
    logic [15:0]                 rsvd_hi;
    logic [`SCHED_SLOT_W-1:0]    slot;
    logic [10:0]                 rsvd_lo;
  } ctrl_msg_t;

  // Host command word
  typedef struct packed {
    logic        write;
    logic        to_interface;
    logic        sched;
    logic [20:0] rsvd;
    logic [3:0]  index;
    logic [3:0]  reg_code;
  } host_cmd_t;

  // Descriptor handed back to an interface
  typedef struct packed {
    logic                        drop;
    logic [31:0]                 hash;
    logic [`SCHED_CORE_W-1:0]    core;
    logic [`SCHED_SLOT_W-1:0]    slot;
  } rx_desc_t;

  // One bit per core
  typedef logic [`SCHED_CORE_COUNT-1:0] core_mask_t;

endpackage

`default_nettype wire

// File: source/sched_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sched_fifo #(
  parameter int DEPTH = 4,
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst_r,
  input  logic [WIDTH-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready,
  output logic [WIDTH-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

  // Pointers wrap at DEPTH so any depth works
  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_overfill: assert property (@(posedge clk) disable iff (rst_r)
    count <= CNT_W'(DEPTH));

endmodule

`default_nettype wire

// File: source/slot_keeper.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_scheduler_settings.svh"

module slot_keeper (
  input  logic                     clk,
  input  logic                     rst_r,
  input  logic                     flush,
  input  logic                     init_valid,
  input  logic                     release_valid,
  input  logic [`SCHED_SLOT_W-1:0] slot_in,
  input  logic                     take,
  output logic [`SCHED_SLOT_W-1:0] slot_out,
  output logic                     slot_valid,
  output logic [`SCHED_SLOT_W-1:0] slot_count,
  output logic                     enq_err
);

  localparam int PTR_W = $clog2(`SCHED_SLOT_COUNT);

  logic [`SCHED_SLOT_W-1:0] pool [`SCHED_SLOT_COUNT];
  logic [PTR_W-1:0]         rd_ptr;
  logic [PTR_W-1:0]         wr_ptr;
  logic [`SCHED_SLOT_W-1:0] init_n;
  logic                     full;
  logic                     put;

  assign full       = (slot_count == `SCHED_SLOT_W'(`SCHED_SLOT_COUNT));
  assign slot_valid = (slot_count != '0);
  assign slot_out   = pool[rd_ptr];

  // Init value larger than the pool is clamped
  assign init_n = (slot_in > `SCHED_SLOT_W'(`SCHED_SLOT_COUNT)) ?
                  `SCHED_SLOT_W'(`SCHED_SLOT_COUNT) : slot_in;

  // A release fits a full pool only when the head leaves in the same cycle
  assign put = release_valid && (!full || take);

  // Init writes 1..N everywhere, the count decides how many are live
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int k = 0; k < `SCHED_SLOT_COUNT; k++)
        pool[k] <= `SCHED_SLOT_W'(k + 1);
    end else if (put) begin
      pool[wr_ptr] <= slot_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      rd_ptr     <= '0;
      wr_ptr     <= '0;
      slot_count <= '0;
      enq_err    <= 1'b0;
    end else if (init_valid) begin
      rd_ptr     <= '0;
      wr_ptr     <= PTR_W'(init_n);
      slot_count <= init_n;
      enq_err    <= 1'b0;
    end else begin
      if (take)
        rd_ptr <= rd_ptr + 1'b1;
      if (put)
        wr_ptr <= wr_ptr + 1'b1;
      case ({put, take})
        2'b10:   slot_count <= slot_count + 1'b1;
        2'b01:   slot_count <= slot_count - 1'b1;
        default: slot_count <= slot_count;
      endcase
      enq_err <= release_valid && !put;
    end
  end

  a_take_needs_slot: assert property (@(posedge clk) disable iff (rst_r)
    take |-> slot_valid);

endmodule

`default_nettype wire

// File: tb/sched_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_scheduler_settings.svh"

module sched_checker
  import rx_scheduler_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_r,
  input  rx_desc_t                   desc [`SCHED_IF_COUNT],
  input  logic [`SCHED_IF_COUNT-1:0] desc_valid,
  input  logic [`SCHED_IF_COUNT-1:0] desc_ready,
  input  logic [`SCHED_IF_COUNT-1:0] hash_ready,
  input  logic [31:0]                host_rd_data,
  input  logic                       exp_valid,
  input  logic [`SCHED_IF_W-1:0]     exp_if,
  input  rx_desc_t                   exp_desc,
  input  logic                       rd_check,
  input  logic [31:0]                rd_expected,
  output int                         pending,
  output int                         error_count,
  output int                         desc_count,
  output int                         read_count
);

  // Expected descriptors, one queue per interface in hash order
  rx_desc_t exp_q [`SCHED_IF_COUNT][$];
  logic     was_reset;

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      error_count++;
      $display("FAILED at %0d ns: %s is %0h, expected %0h", $time, name, got, expected);
    end
  endtask

  always @(posedge clk) begin
    rx_desc_t expected;
    // First edge out of reset
    if (was_reset && !rst_r) begin
      check_value("desc_valid", 64'(desc_valid), 64'(0));
      check_value("hash_ready", 64'(hash_ready), 64'({`SCHED_IF_COUNT{1'b1}}));
    end
    was_reset <= rst_r;

    if (!rst_r) begin
      if (exp_valid) begin
        exp_q[exp_if].push_back(exp_desc);
        pending++;
      end

      for (int i = 0; i < `SCHED_IF_COUNT; i++) begin
        if (desc_valid[i] && desc_ready[i]) begin
          desc_count++;
          if (exp_q[i].size() == 0) begin
            error_count++;
            $display("At %0d ns a descriptor left interface %0d with none expected",
                     $time, i);
          end else begin
            expected = exp_q[i].pop_front();
            pending--;
            check_value($sformatf("desc[%0d].drop", i), 64'(desc[i].drop), 64'(expected.drop));
            check_value($sformatf("desc[%0d].hash", i), 64'(desc[i].hash), 64'(expected.hash));
            check_value($sformatf("desc[%0d].core", i), 64'(desc[i].core), 64'(expected.core));
            check_value($sformatf("desc[%0d].slot", i), 64'(desc[i].slot), 64'(expected.slot));
          end
        end
      end

      if (rd_check) begin
        read_count++;
        check_value("host_rd_data", 64'(host_rd_data), 64'(rd_expected));
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/sched_stimulus.txt
# All fields hex. W/R: to_if reg idx data|expected  I/L: core n|slot  C: if lines
# H: if hash drop core slot  B: backpressure 0|1  N: idle cycles  S: wait for descriptors
R 0 0 0 00000000
R 0 7 0 FEFEFEFE
R 1 0 0 FEFEFEFE
W 0 0 0 0000000F
W 0 1 0 000000FC
R 0 1 0 0000000C
W 0 0 0 00000007
R 0 1 0 00000004
R 0 0 0 00000007
W 0 0 0 000000FF
W 0 1 0 000000FF
R 0 1 0 000000FF
# Core 2 with four slots
I 2 4
R 0 3 2 00000004
H 0 12348ABC 0 2 1
S
R 0 3 2 00000003
H 1 CAFE9001 0 2 2
S
R 0 3 2 00000002
H 2 0BACA0A0 0 2 3
H 2 7770B777 0 2 4
S
R 0 3 2 00000000
# Drops at the written limit, then a retry until a release
W 1 3 0 00000100
C 0 0100
H 0 55548123 1 2 0
H 0 33329F00 1 2 0
S
R 1 2 0 00000002
C 0 00FF
H 0 8888A111 0 2 9
N 20
L 2 9
S
R 1 2 0 00000002
C 0 0000
# Flush of core 6
I 6 8
R 0 3 6 00000008
W 0 2 0 00000040
R 0 3 6 00000000
# Random back-pressure on all interfaces
B 1
I 0 6
I 1 6
I 3 6
H 0 10001234 0 0 1
H 1 11104000 0 1 1
H 2 6666C000 0 3 1
H 0 20002345 0 0 2
H 1 22225111 0 1 2
H 2 7776D111 0 3 2
H 0 30003456 0 0 3
H 1 33366222 0 1 3
H 2 8888E222 0 3 3
H 0 40000123 0 0 4
H 1 44447333 0 1 4
H 2 9998F333 0 3 4
H 0 50001FFF 0 0 5
H 1 55544444 0 1 5
S
B 0
R 0 3 0 00000001
R 0 3 3 00000002

// File: tb/tb_rx_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_scheduler_settings.svh"

module tb_rx_scheduler
  import rx_scheduler_pkg::*;
();

  localparam int HANDSHAKE_LIMIT = 2000;
  localparam int DRAIN_LIMIT     = 5000;

  logic                         clk;
  logic                         rst_r;
  logic [31:0]                  hash [`SCHED_IF_COUNT];
  logic [`SCHED_IF_COUNT-1:0]   hash_valid;
  logic [`SCHED_IF_COUNT-1:0]   hash_ready;
  logic [`SCHED_LINE_W-1:0]     line_count [`SCHED_IF_COUNT];
  ctrl_msg_t                    ctrl_msg;
  logic [`SCHED_CORE_W-1:0]     ctrl_src;
  logic                         ctrl_valid;
  host_cmd_t                    host_cmd;
  logic [31:0]                  host_wr_data;
  logic                         host_cmd_valid;
  logic [31:0]                  host_rd_data;
  rx_desc_t                     desc [`SCHED_IF_COUNT];
  logic [`SCHED_IF_COUNT-1:0]   desc_valid;
  logic [`SCHED_IF_COUNT-1:0]   desc_ready;

  // Expectations handed to the checker
  logic                         exp_valid;
  logic [`SCHED_IF_W-1:0]       exp_if;
  rx_desc_t                     exp_desc;
  logic                         rd_check;
  logic [31:0]                  rd_expected;
  int                           pending;
  int                           error_count;
  int                           desc_count;
  int                           read_count;

  logic                         back_pressure;
  logic [15:0]                  lfsr;
  int                           timeouts;
  logic                         bad_input;

  rx_scheduler i_dut (.*);

  sched_checker i_checker (.*);

  always #50 clk = ~clk;

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  // Back-pressure source takes one LFSR step per ready bit
  initial begin
    desc_ready = '1;
    lfsr       = 16'd42418;
    forever begin
      @(posedge clk);
      #1;
      for (int i = 0; i < `SCHED_IF_COUNT; i++) begin
        if (back_pressure) begin
          lfsr          = lfsr_next(lfsr);
          desc_ready[i] = lfsr[0];
        end else begin
          desc_ready[i] = 1'b1;
        end
      end
    end
  end

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic host_write(input logic to_if, input logic [3:0] code,
                            input logic [3:0] idx, input logic [31:0] data);
    host_cmd              = '0;
    host_cmd.write        = 1'b1;
    host_cmd.sched        = 1'b1;
    host_cmd.to_interface = to_if;
    host_cmd.index        = idx;
    host_cmd.reg_code     = code;
    host_wr_data          = data;
    host_cmd_valid        = 1'b1;
    @(posedge clk);
    #1;
    host_cmd_valid = 1'b0;
    host_cmd.write = 1'b0;
    // Register changes two cycles after the strobe
    idle_cycles(2);
  endtask

  task automatic host_read(input logic to_if, input logic [3:0] code,
                           input logic [3:0] idx, input logic [31:0] expected);
    host_cmd              = '0;
    host_cmd.sched        = 1'b1;
    host_cmd.to_interface = to_if;
    host_cmd.index        = idx;
    host_cmd.reg_code     = code;
    rd_expected           = expected;
    // Read data settles three cycles after the command
    idle_cycles(3);
    rd_check = 1'b1;
    @(posedge clk);
    #1;
    rd_check = 1'b0;
  endtask

  task automatic ctrl_send(input logic [3:0] msg_type, input logic [`SCHED_CORE_W-1:0] src,
                           input logic [`SCHED_SLOT_W-1:0] slot);
    ctrl_msg          = '0;
    ctrl_msg.msg_type = msg_type;
    ctrl_msg.slot     = slot;
    ctrl_src          = src;
    ctrl_valid        = 1'b1;
    @(posedge clk);
    #1;
    ctrl_valid = 1'b0;
    idle_cycles(3);
  endtask

  task automatic set_line_count(input logic [`SCHED_IF_W-1:0] ifn,
                                input logic [`SCHED_LINE_W-1:0] value);
    line_count[ifn] = value;
    // Two register stages before almost_full follows
    idle_cycles(3);
  endtask

  task automatic send_hash(input logic [`SCHED_IF_W-1:0] ifn, input logic [31:0] value,
                           input logic drop, input logic [`SCHED_CORE_W-1:0] core,
                           input logic [`SCHED_SLOT_W-1:0] slot);
    int budget;
    budget        = HANDSHAKE_LIMIT;
    exp_if        = ifn;
    exp_desc.drop = drop;
    exp_desc.hash = value;
    exp_desc.core = core;
    exp_desc.slot = slot;
    exp_valid     = 1'b1;
    @(posedge clk);
    #1;
    exp_valid       = 1'b0;
    hash[ifn]       = value;
    hash_valid[ifn] = 1'b1;
    while (!hash_ready[ifn] && budget > 0) begin
      @(posedge clk);
      #1;
      budget--;
    end
    if (!hash_ready[ifn]) begin
      $display("Timeout: hash_ready on interface %0d stayed low", ifn);
      timeouts++;
    end else begin
      @(posedge clk);
      #1;
    end
    hash_valid[ifn] = 1'b0;
  endtask

  task automatic wait_drain();
    int budget;
    budget = DRAIN_LIMIT;
    while (pending != 0 && budget > 0) begin
      @(posedge clk);
      #1;
      budget--;
    end
    if (pending != 0) begin
      $display("Timeout: %0d expected descriptors never arrived", pending);
      timeouts++;
    end
  endtask

  initial begin
    int          fd;
    string       line;
    string       args;
    logic [7:0]  op;
    logic [31:0] field [5];
    clk            = 1'b0;
    rst_r          = 1'b1;
    hash_valid     = '0;
    ctrl_msg       = '0;
    ctrl_src       = '0;
    ctrl_valid     = 1'b0;
    host_cmd       = '0;
    host_wr_data   = '0;
    host_cmd_valid = 1'b0;
    exp_valid      = 1'b0;
    exp_if         = '0;
    exp_desc       = '0;
    rd_check       = 1'b0;
    rd_expected    = '0;
    back_pressure  = 1'b0;
    timeouts       = 0;
    bad_input      = 1'b0;
    for (int i = 0; i < `SCHED_IF_COUNT; i++) begin
      hash[i]       = '0;
      line_count[i] = '0;
    end

    repeat (8) @(posedge clk);
    #1;
    rst_r = 1'b0;
    idle_cycles(1);

    fd = $fopen("tb/sched_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file tb/sched_stimulus.txt");
      bad_input = 1'b1;
    end

    while (timeouts == 0 && !bad_input && $fgets(line, fd) > 0) begin
      op   = line.getc(0);
      args = (line.len() > 2) ? line.substr(2, line.len() - 1) : "";
      for (int k = 0; k < 5; k++)
        field[k] = '0;
      void'($sscanf(args, "%h %h %h %h %h", field[0], field[1], field[2], field[3],
                    field[4]));
      case (op)
        "#", " ", "\n", "\r": ;
        "W": host_write(field[0][0], field[1][3:0], field[2][3:0], field[3]);
        "R": host_read(field[0][0], field[1][3:0], field[2][3:0], field[3]);
        "I": ctrl_send(`SCHED_MSG_INIT, field[0][`SCHED_CORE_W-1:0],
                       field[1][`SCHED_SLOT_W-1:0]);
        "L": ctrl_send(`SCHED_MSG_RELEASE, field[0][`SCHED_CORE_W-1:0],
                       field[1][`SCHED_SLOT_W-1:0]);
        "C": set_line_count(field[0][`SCHED_IF_W-1:0], field[1][`SCHED_LINE_W-1:0]);
        "H": send_hash(field[0][`SCHED_IF_W-1:0], field[1], field[2][0],
                       field[3][`SCHED_CORE_W-1:0], field[4][`SCHED_SLOT_W-1:0]);
        "B": back_pressure = field[0][0];
        "N": idle_cycles(int'(field[0]));
        "S": wait_drain();
        default: begin
          $display("Unknown opcode in stimulus line: %s", line);
          bad_input = 1'b1;
        end
      endcase
    end
    if (fd != 0)
      $fclose(fd);

    if (timeouts == 0)
      wait_drain();
    $display("Summary: %0d descriptors and %0d host reads checked, %0d errors, %0d timeouts",
             desc_count, read_count, error_count, timeouts);
    if (timeouts == 0 && !bad_input && error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
